// File: fix_rx_cfg.svh
// fix receive configuration
`ifndef FIX_RX_CFG_SVH
`define FIX_RX_CFG_SVH

// binary tag number, accumulated from the decimal digits before "="
`define FIX_TAG_W 32

// one value word, eight ascii characters or one binary number
`define FIX_VALUE_W 64

// MsgSeqNum and NewSeqNo width
`define FIX_SEQ_W 32

// highest accepted BeginString, last three chars of "FIX.4.3"
`define FIX_SUPPORTED_VER 24'h342e33

`endif

// File: fix_tags_pkg.sv
// fix wire-level types
`include "fix_rx_cfg.svh"

package fix_tags_pkg;

	// tag numbers the receive path knows about
	typedef enum logic [`FIX_TAG_W-1:0] {
		tag_begin_seq_no   = 7,    // resend request range start
		tag_begin_string   = 8,
		tag_body_length    = 9,
		tag_checksum       = 10,
		tag_end_seq_no     = 16,   // resend request range end
		tag_msg_seq_num    = 34,
		tag_msg_type       = 35,
		tag_new_seq_no     = 36,
		tag_poss_dup       = 43,
		tag_sender_comp_id = 49,
		tag_sending_time   = 52,
		tag_target_comp_id = 56,
		tag_gap_fill       = 123
	} fix_tag_e;

	// single character MsgType codes
	typedef enum logic [7:0] {
		msg_heartbeat  = 8'h30,   // "0"
		msg_test_req   = 8'h31,   // "1"
		msg_resend_req = 8'h32,   // "2"
		msg_seq_reset  = 8'h34,   // "4"
		msg_logout     = 8'h35,   // "5"
		msg_logon      = 8'h41    // "A"
	} fix_msgtype_e;

	// same value word, read as text or as a number depending on the tag
	typedef union packed {
		logic [`FIX_VALUE_W-1:0] text;   // last eight chars, newest in [7:0]
		logic [`FIX_VALUE_W-1:0] num;    // decimal digits folded to binary
	} fix_value_u;

	typedef struct packed {
		logic                  tag_valid;   // strobe, tag complete
		logic [`FIX_TAG_W-1:0] tag;         // held through the value
		logic                  val_valid;   // strobe, value complete
		fix_value_u            val;
		logic                  som;         // with the tag 8 strobe
		logic                  eom;         // with the tag 10 strobe
	} fix_field_t;

endpackage

// File: fix_session_pkg.sv
// fix session-level types
`include "fix_rx_cfg.svh"

package fix_session_pkg;

	// what the message was, as seen by session logic
	typedef enum logic [3:0] {
		cls_none       = 4'd0,   // header rejected before MsgType
		cls_logon      = 4'd1,
		cls_heartbeat  = 4'd2,
		cls_test_req   = 4'd3,
		cls_resend_req = 4'd4,
		cls_seq_reset  = 4'd5,   // reset mode, GapFillFlag absent or N
		cls_gap_fill   = 4'd6,   // sequence reset with GapFillFlag Y
		cls_logout     = 4'd7,
		cls_unknown    = 4'd8    // any other MsgType
	} fix_class_e;

	// one error per message, first match in precedence order
	typedef enum logic [3:0] {
		err_ok                   = 4'd0,
		err_garbled              = 4'd1,   // bad checksum or header order
		err_unsupported_version  = 4'd2,
		err_required_tag_missing = 4'd3,
		err_seq_low              = 4'd4,
		err_seq_high             = 4'd5
	} fix_err_e;

	// Result handed to the session manager on each result pulse.
	// new_seq only carries meaning for sequence reset and gap fill.
	typedef struct packed {
		fix_class_e            msg_class;
		fix_err_e              err;
		logic [`FIX_SEQ_W-1:0] msg_seq;    // MsgSeqNum as received
		logic [`FIX_SEQ_W-1:0] new_seq;    // NewSeqNo, zero when absent
		logic                  poss_dup;   // PossDupFlag was Y
	} fix_rx_result_t;

endpackage

// File: fix_field_parser.sv
// fix tag/value field parser
`timescale 1ns/100ps
`include "fix_rx_cfg.svh"

module fix_field_parser import fix_tags_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic [7:0] byte_i,
	input  logic       byte_valid_i,
	output fix_field_t field_o
);

	localparam logic [7:0] soh_char = 8'h01;   // field delimiter
	localparam logic [7:0] eq_char  = 8'h3d;   // "="

	logic                  val_phase_q;   // 0 tag digits, 1 value chars
	logic [`FIX_TAG_W-1:0] tag_acc_q;     // tag being built
	fix_value_u            val_acc_q;     // value being built
	logic [`FIX_TAG_W-1:0] tag_q;         // last complete tag
	fix_value_u            val_q;         // last complete value
	logic                  tag_stb_q;
	logic                  val_stb_q;
	logic                  som_q;
	logic                  eom_q;
	logic [7:0]            digit;
	logic                  num_tag;

	assign digit = byte_i - 8'h30;   // wraps high for non-digits

	// numeric tags get the binary view, everything else stays ascii
	always_comb begin
		case (tag_q)
			tag_body_length,
			tag_checksum,
			tag_msg_seq_num,
			tag_new_seq_no,
			tag_begin_seq_no,
			tag_end_seq_no: num_tag = 1'b1;
			default:        num_tag = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		tag_stb_q <= 1'b0;   // strobes last one cycle
		val_stb_q <= 1'b0;
		som_q     <= 1'b0;
		eom_q     <= 1'b0;
		if (rst) begin
			val_phase_q <= 1'b0;
			tag_acc_q   <= '0;
			tag_q       <= '0;
		end else if (byte_valid_i) begin
			if (!val_phase_q) begin
				if (byte_i == eq_char) begin
					// tag done, open the value
					tag_q       <= tag_acc_q;
					tag_stb_q   <= 1'b1;
					som_q       <= (tag_acc_q == tag_begin_string);
					eom_q       <= (tag_acc_q == tag_checksum);
					val_phase_q <= 1'b1;
					tag_acc_q   <= '0;
					val_acc_q   <= '0;
				end else if (byte_i == soh_char) begin
					tag_acc_q <= '0;   // stray delimiter, resync
				end else if (digit < 8'd10) begin
					tag_acc_q <= tag_acc_q * 32'd10 + {24'd0, digit};
				end
			end else if (byte_i == soh_char) begin
				val_q       <= val_acc_q;
				val_stb_q   <= 1'b1;
				val_phase_q <= 1'b0;
			end else if (num_tag) begin
				val_acc_q.num <= val_acc_q.num * 64'd10 + {56'd0, digit};
			end else begin
				val_acc_q.text <= {val_acc_q.text[55:0], byte_i};   // shift in, keep last 8
			end
		end
	end

	assign field_o = '{
		tag_valid: tag_stb_q,
		tag:       tag_q,
		val_valid: val_stb_q,
		val:       val_q,
		som:       som_q,
		eom:       eom_q
	};

endmodule

// File: fix_checksum.sv
// fix trailer checksum
`timescale 1ns/100ps

module fix_checksum import fix_tags_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic [7:0] byte_i,
	input  logic       byte_valid_i,
	input  fix_field_t field_i,
	output logic       checksum_ok_o
);

	// "8" + "=" are already gone by the time som shows up
	localparam logic [7:0] hdr_sum = 8'h75;

	logic [7:0] sum_q;      // running sum of every byte
	logic [7:0] snap_q;     // sum up to and including the last SOH
	logic [7:0] frozen_q;   // snapshot taken at "10="
	logic [7:0] byte_add;
	logic [7:0] sum_next;

	assign byte_add = byte_valid_i ? byte_i : 8'h00;
	assign sum_next = (field_i.som ? hdr_sum : sum_q) + byte_add;   // restart on som

	always_ff @(posedge clk) begin
		if (rst) begin
			sum_q         <= '0;
			snap_q        <= '0;
			frozen_q      <= '0;
			checksum_ok_o <= 1'b0;
		end else begin
			sum_q <= sum_next;
			if (byte_valid_i && byte_i == 8'h01)
				snap_q <= sum_next;
			if (field_i.tag_valid && field_i.eom)
				frozen_q <= snap_q;   // covers up to the SOH before "10="
			if (field_i.som)
				checksum_ok_o <= 1'b0;
			else if (field_i.val_valid && field_i.tag == tag_checksum)
				checksum_ok_o <= (frozen_q == field_i.val.num[7:0]);   // mod 256
		end
	end

endmodule

// File: fix_rx_msg_processor.sv
// fix receive message processor
`timescale 1ns/100ps
`include "fix_rx_cfg.svh"

module fix_rx_msg_processor import fix_tags_pkg::*, fix_session_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  fix_field_t            field_i,
	input  logic                  checksum_ok_i,
	input  logic [`FIX_SEQ_W-1:0] expected_seq_i,
	output logic                  result_valid_o,
	output fix_rx_result_t        result_o
);

	// one-hot, header tags in fixed order then free body
	typedef enum logic [10:0] {
		st_idle     = 11'h001,   // wait for 8 with som
		st_ver      = 11'h002,
		st_len_tag  = 11'h004,
		st_len_val  = 11'h008,
		st_seq_tag  = 11'h010,
		st_seq_val  = 11'h020,
		st_type_tag = 11'h040,
		st_type_val = 11'h080,
		st_body     = 11'h100,
		st_cks      = 11'h200,   // tag 10 seen, wait for its value
		st_eval     = 11'h400    // checksum_ok now valid
	} state_e;

	state_e                state_q;
	state_e                state_d;
	logic                  fail;       // header rejected this cycle
	fix_err_e              fail_err;
	logic [`FIX_SEQ_W-1:0] msg_seq_q;
	logic [`FIX_SEQ_W-1:0] new_seq_q;
	fix_value_u            msg_type_q;
	logic                  poss_dup_q;
	logic                  gap_fill_q;
	logic                  has_sender_q;
	logic                  has_target_q;
	logic                  has_time_q;
	logic                  has_begin_q;
	logic                  has_end_q;
	logic                  has_new_seq_q;
	fix_class_e            cls;
	fix_err_e              eval_err;
	logic                  missing;

	function automatic logic is_yes(fix_value_u v);
		return v.text == 64'h59;   // exactly "Y"
	endfunction

	// header walk
	always_comb begin
		state_d  = state_q;
		fail     = 1'b0;
		fail_err = err_garbled;
		case (state_q)
			st_idle: if (field_i.tag_valid && field_i.som) state_d = st_ver;
			st_ver: if (field_i.val_valid) begin
				if (field_i.val.text[23:0] > `FIX_SUPPORTED_VER) begin
					fail     = 1'b1;
					fail_err = err_unsupported_version;
					state_d  = st_idle;
				end else begin
					state_d = st_len_tag;
				end
			end
			st_len_tag: if (field_i.tag_valid) begin
				fail    = (field_i.tag != tag_body_length);
				state_d = fail ? st_idle : st_len_val;
			end
			st_len_val: if (field_i.val_valid) state_d = st_seq_tag;   // length not checked
			st_seq_tag: if (field_i.tag_valid) begin
				fail    = (field_i.tag != tag_msg_seq_num);
				state_d = fail ? st_idle : st_seq_val;
			end
			st_seq_val: if (field_i.val_valid) state_d = st_type_tag;
			st_type_tag: if (field_i.tag_valid) begin
				fail    = (field_i.tag != tag_msg_type);
				state_d = fail ? st_idle : st_type_val;
			end
			st_type_val: if (field_i.val_valid) state_d = st_body;
			st_body: if (field_i.tag_valid && field_i.eom) state_d = st_cks;
			st_cks: if (field_i.val_valid) state_d = st_eval;
			default: state_d = st_idle;   // st_eval lasts one cycle
		endcase
	end

	// MsgType to class, multi-char types end up unknown
	always_comb begin
		cls = cls_unknown;
		if (msg_type_q.text[63:8] == '0) begin
			case (msg_type_q.text[7:0])
				msg_logon:      cls = cls_logon;
				msg_heartbeat:  cls = cls_heartbeat;
				msg_test_req:   cls = cls_test_req;
				msg_resend_req: cls = cls_resend_req;
				msg_seq_reset:  cls = gap_fill_q ? cls_gap_fill : cls_seq_reset;
				msg_logout:     cls = cls_logout;
				default:        cls = cls_unknown;
			endcase
		end
	end

	assign missing = !(has_sender_q && has_target_q && has_time_q)
		|| (cls == cls_resend_req && !(has_begin_q && has_end_q))
		|| ((cls == cls_seq_reset || cls == cls_gap_fill) && !has_new_seq_q);

	// precedence: checksum, tags, low, high; reset mode skips seq checks
	always_comb begin
		if (!checksum_ok_i)
			eval_err = err_garbled;
		else if (missing)
			eval_err = err_required_tag_missing;
		else if (cls != cls_seq_reset && msg_seq_q < expected_seq_i && !poss_dup_q)
			eval_err = err_seq_low;
		else if (cls != cls_seq_reset && msg_seq_q > expected_seq_i)
			eval_err = err_seq_high;
		else
			eval_err = err_ok;
	end

	// field capture, flags cleared when a new message opens
	always_ff @(posedge clk) begin
		if (rst || (state_q == st_idle && state_d == st_ver)) begin
			poss_dup_q    <= 1'b0;
			gap_fill_q    <= 1'b0;
			has_sender_q  <= 1'b0;
			has_target_q  <= 1'b0;
			has_time_q    <= 1'b0;
			has_begin_q   <= 1'b0;
			has_end_q     <= 1'b0;
			has_new_seq_q <= 1'b0;
			new_seq_q     <= '0;
		end else if (field_i.val_valid) begin
			if (state_q == st_seq_val)
				msg_seq_q <= field_i.val.num[`FIX_SEQ_W-1:0];
			if (state_q == st_type_val)
				msg_type_q <= field_i.val;
			if (state_q == st_body) begin
				case (field_i.tag)
					tag_poss_dup:       poss_dup_q   <= is_yes(field_i.val);
					tag_gap_fill:       gap_fill_q   <= is_yes(field_i.val);
					tag_sender_comp_id: has_sender_q <= 1'b1;
					tag_target_comp_id: has_target_q <= 1'b1;
					tag_sending_time:   has_time_q   <= 1'b1;
					tag_begin_seq_no:   has_begin_q  <= 1'b1;
					tag_end_seq_no:     has_end_q    <= 1'b1;
					tag_new_seq_no: begin
						has_new_seq_q <= 1'b1;
						new_seq_q     <= field_i.val.num[`FIX_SEQ_W-1:0];
					end
					default: ;   // other body tags pass by
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q        <= st_idle;
			result_valid_o <= 1'b0;
			result_o       <= '0;
		end else begin
			state_q        <= state_d;
			result_valid_o <= fail || (state_q == st_eval);
			if (fail)
				result_o <= '{cls_none, fail_err, '0, '0, 1'b0};
			else if (state_q == st_eval)
				result_o <= '{cls, eval_err, msg_seq_q, new_seq_q, poss_dup_q};
		end
	end

endmodule

// File: fix_seq_tracker.sv
// fix incoming sequence tracker
`timescale 1ns/100ps
`include "fix_rx_cfg.svh"

module fix_seq_tracker import fix_session_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  result_valid_i,
	input  fix_rx_result_t        result_i,
	output logic [`FIX_SEQ_W-1:0] expected_seq_o
);

	logic is_reset;   // either flavour of sequence reset
	logic accept;     // clean result this cycle

	assign is_reset = (result_i.msg_class == cls_seq_reset)
		|| (result_i.msg_class == cls_gap_fill);
	assign accept = result_valid_i && (result_i.err == err_ok);

	always_ff @(posedge clk) begin
		if (rst) begin
			expected_seq_o <= (`FIX_SEQ_W)'(1);   // session starts at 1
		end else if (accept) begin
			if (is_reset)
				expected_seq_o <= result_i.new_seq;   // jump to NewSeqNo
			else if (result_i.msg_seq == expected_seq_o)
				expected_seq_o <= expected_seq_o + 1'b1;
			// poss dup below expected is ok but does not move the counter
		end
	end

endmodule

// File: fix_rx_top.sv
// fix receive path top
`timescale 1ns/100ps
`include "fix_rx_cfg.svh"

module fix_rx_top import fix_tags_pkg::*, fix_session_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [7:0]            byte_i,
	input  logic                  byte_valid_i,
	output logic                  result_valid_o,
	output fix_rx_result_t        result_o,
	output logic [`FIX_SEQ_W-1:0] expected_seq_o
);

	fix_field_t field;         // parser to processor and checksum
	logic       checksum_ok;   // level, valid after tag 10 value

	fix_field_parser u_parser (
		.clk          (clk),
		.rst          (rst),
		.byte_i       (byte_i),
		.byte_valid_i (byte_valid_i),
		.field_o      (field)
	);

	fix_checksum u_checksum (
		.clk           (clk),
		.rst           (rst),
		.byte_i        (byte_i),
		.byte_valid_i  (byte_valid_i),
		.field_i       (field),
		.checksum_ok_o (checksum_ok)
	);

	fix_rx_msg_processor u_proc (
		.clk            (clk),
		.rst            (rst),
		.field_i        (field),
		.checksum_ok_i  (checksum_ok),
		.expected_seq_i (expected_seq_o),
		.result_valid_o (result_valid_o),
		.result_o       (result_o)
	);

	fix_seq_tracker u_seq (
		.clk            (clk),
		.rst            (rst),
		.result_valid_i (result_valid_o),   // counter follows each result
		.result_i       (result_o),
		.expected_seq_o (expected_seq_o)
	);

endmodule

// File: fix_rx_asserts.sv
// fix receive path assertions
`timescale 1ns/100ps
`include "fix_rx_cfg.svh"

module fix_rx_asserts import fix_session_pkg::*; (
	input logic                  clk,
	input logic                  rst,
	input logic                  result_valid_i,
	input fix_rx_result_t        result_i,
	input logic [`FIX_SEQ_W-1:0] expected_seq_i
);

	// result is a one-cycle pulse
	a_pulse_one_cycle: assert property (@(posedge clk) disable iff (rst)
		result_valid_i |=> !result_valid_i)
		else $error("result_valid_o stayed high for two cycles");

	// counter moves only right after a result
	a_seq_after_result: assert property (@(posedge clk) disable iff (rst)
		!$stable(expected_seq_i) |-> $past(result_valid_i))
		else $error("expected_seq_o changed with no result pulse before it");

	a_result_held: assert property (@(posedge clk) disable iff (rst)
		!result_valid_i |-> $stable(result_i))   // held between pulses
		else $error("result_o changed while result_valid_o was low");

endmodule

bind fix_rx_top fix_rx_asserts u_asserts (
	.clk            (clk),
	.rst            (rst),
	.result_valid_i (result_valid_o),
	.result_i       (result_o),
	.expected_seq_i (expected_seq_o)
);

// File: fix_rx_tb.sv
// fix receive path testbench
`timescale 1ns/100ps
`include "fix_rx_cfg.svh"

module fix_rx_tb import fix_session_pkg::*; ();

	logic                  clk;
	logic                  rst;
	logic [7:0]            byte_i;
	logic                  byte_valid_i;
	logic                  result_valid_o;
	fix_rx_result_t        result_o;
	logic [`FIX_SEQ_W-1:0] expected_seq_o;

	// case table, one entry per message
	string      msg_tab[$];   // fields before the trailer, "|" stands for SOH
	fix_class_e cls_tab[$];
	fix_err_e   err_tab[$];
	int         seq_tab[$];   // MsgSeqNum sent
	int         new_tab[$];   // NewSeqNo sent, 0 if none
	bit         bad_tab[$];   // corrupt the checksum
	int         hit_tab[$];   // 0 final SOH, 1 BeginString SOH, 2 third "="

	fix_rx_result_t got_q[$];       // results caught by the monitor
	int             got_cyc_q[$];   // edge count at which each was seen
	logic [7:0]     msg_bytes[$];   // current message on the wire
	int             hit_pos;        // byte that should trigger the result
	int             hit_cyc;        // edge at which that byte was driven
	int             seed = 32'hcedb651b;
	int             cyc = 0;
	int             model_seq = 1;  // expected incoming sequence number
	int             checks = 0;
	int             val_errs = 0;
	int             time_errs = 0;
	int             timeouts = 0;

	fix_rx_top dut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (!rst && result_valid_o) begin
			got_q.push_back(result_o);
			got_cyc_q.push_back(cyc);
		end
	end

	function automatic string std_fields(int seq, string typ);
		return $sformatf("8=FIX.4.2|9=40|34=%0d|35=%s|49=CLI|56=SRV|52=T1|", seq, typ);
	endfunction

	// substring search over the message text
	function automatic bit has_field(string msg, string fld);
		int i;
		for (i = 0; i + fld.len() <= msg.len(); i++)
			if (msg.substr(i, i + fld.len() - 1) == fld)
				return 1'b1;
		return 1'b0;
	endfunction

	task automatic add_case(string msg, fix_class_e cls, fix_err_e err, int seq, int nseq,
		bit bad, int hit);
		msg_tab.push_back(msg);
		cls_tab.push_back(cls);
		err_tab.push_back(err);
		seq_tab.push_back(seq);
		new_tab.push_back(nseq);
		bad_tab.push_back(bad);
		hit_tab.push_back(hit);
	endtask

	task automatic load_table();
		add_case({std_fields(1, "A"), "98=0|108=30|"}, cls_logon, err_ok, 1, 0, 0, 0);
		add_case(std_fields(2, "0"), cls_heartbeat, err_ok, 2, 0, 0, 0);
		add_case({std_fields(3, "1"), "112=T1|"}, cls_test_req, err_ok, 3, 0, 0, 0);
		add_case(std_fields(4, "0"), cls_heartbeat, err_garbled, 4, 0, 1, 0);   // bad sum
		add_case("8=FIX.4.2|9=40|35=0|34=4|49=CLI|56=SRV|52=T1|",
			cls_none, err_garbled, 4, 0, 0, 2);   // 35 ahead of 34
		add_case(std_fields(4, "0"), cls_heartbeat, err_ok, 4, 0, 0, 0);
		add_case("8=FIX.4.4|9=40|34=5|35=0|49=CLI|56=SRV|52=T1|",
			cls_none, err_unsupported_version, 5, 0, 0, 1);
		add_case("8=FIX.4.2|9=40|34=5|35=0|49=CLI|52=T1|",
			cls_heartbeat, err_required_tag_missing, 5, 0, 0, 0);   // no 56
		add_case(std_fields(3, "0"), cls_heartbeat, err_seq_low, 3, 0, 0, 0);
		add_case({std_fields(3, "0"), "43=Y|"}, cls_heartbeat, err_ok, 3, 0, 0, 0);
		add_case(std_fields(9, "0"), cls_heartbeat, err_seq_high, 9, 0, 0, 0);
		add_case({std_fields(5, "4"), "123=Y|36=8|"}, cls_gap_fill, err_ok, 5, 8, 0, 0);
		add_case({std_fields(2, "4"), "36=20|"}, cls_seq_reset, err_ok, 2, 20, 0, 0);
		add_case(std_fields(20, "5"), cls_logout, err_ok, 20, 0, 0, 0);
	endtask

	// text to bytes, then "10=nnn" over everything up to the last SOH
	task automatic build_msg(int k);
		logic [7:0] c;
		int         i;
		int         sum;
		int         n_soh;
		int         n_eq;
		string      trailer;
		msg_bytes.delete();
		sum     = 0;
		n_soh   = 0;
		n_eq    = 0;
		hit_pos = -1;
		for (i = 0; i < msg_tab[k].len(); i++) begin
			c = msg_tab[k][i];
			if (c == "|")
				c = 8'h01;
			if (c == 8'h01 && n_soh == 0 && hit_tab[k] == 1)
				hit_pos = i;
			if (c == "=" && n_eq == 2 && hit_tab[k] == 2)
				hit_pos = i;
			n_soh += (c == 8'h01);
			n_eq  += (c == "=");
			sum   += c;
			msg_bytes.push_back(c);
		end
		trailer = $sformatf("10=%03d", (sum + int'(bad_tab[k])) % 256);   // off by one if bad
		for (i = 0; i < trailer.len(); i++)
			msg_bytes.push_back(trailer[i]);
		msg_bytes.push_back(8'h01);
		if (hit_tab[k] == 0)
			hit_pos = msg_bytes.size() - 1;
	endtask

	task automatic drive_msg();
		int i;
		int gap;
		for (i = 0; i < msg_bytes.size(); i++) begin
			gap = $unsigned($random(seed)) % 3;   // 0..2 idle cycles
			repeat (gap) begin
				@(posedge clk);
				byte_valid_i <= 1'b0;
			end
			@(posedge clk);
			byte_i       <= msg_bytes[i];
			byte_valid_i <= 1'b1;
			if (i == hit_pos)
				hit_cyc = cyc;
		end
		@(posedge clk);
		byte_valid_i <= 1'b0;
	endtask

	task automatic wait_result(output bit ok);
		int n;
		n = 0;
		while (got_q.size() == 0 && n < 200) begin
			@(posedge clk);
			n++;
		end
		ok = (got_q.size() != 0);
	endtask

	task automatic check_case(int k);
		fix_rx_result_t r;
		int             lat;
		int             lat_exp;
		bit             dup_exp;
		r       = got_q.pop_front();
		lat     = got_cyc_q.pop_front() - (hit_cyc + 1);   // from the accepting edge
		lat_exp = (hit_tab[k] == 0) ? 3 : 2;   // trailer pipeline vs header reject
		dup_exp = (cls_tab[k] != cls_none) && has_field(msg_tab[k], "|43=Y|");   // PossDup sent
		checks++;
		assert (r.msg_class == cls_tab[k]) else begin
			$display("ERR case %0d result_o.msg_class %h exp %h", k, r.msg_class, cls_tab[k]);
			val_errs++;
		end
		assert (r.err == err_tab[k]) else begin
			$display("ERR case %0d result_o.err %h exp %h", k, r.err, err_tab[k]);
			val_errs++;
		end
		assert (cls_tab[k] == cls_none || r.msg_seq == seq_tab[k]) else begin
			$display("ERR case %0d result_o.msg_seq %h exp %h", k, r.msg_seq, seq_tab[k]);
			val_errs++;
		end
		assert (r.new_seq == new_tab[k]) else begin
			$display("ERR case %0d result_o.new_seq %h exp %h", k, r.new_seq, new_tab[k]);
			val_errs++;
		end
		assert (r.poss_dup == dup_exp) else begin
			$display("ERR case %0d result_o.poss_dup %h exp %h", k, r.poss_dup, dup_exp);
			val_errs++;
		end
		assert (lat == lat_exp) else begin
			$display("case %0d result came %0d cycles after its byte, not %0d", k, lat, lat_exp);
			time_errs++;
		end
		// session rule on the counter
		if (err_tab[k] == err_ok) begin
			if (cls_tab[k] == cls_seq_reset || cls_tab[k] == cls_gap_fill)
				model_seq = new_tab[k];
			else if (seq_tab[k] == model_seq)
				model_seq++;
		end
		repeat (2) @(posedge clk);   // counter moves one cycle after the pulse
		assert (expected_seq_o == model_seq) else begin
			$display("ERR case %0d expected_seq_o %h exp %h", k, expected_seq_o, model_seq);
			val_errs++;
		end
		assert (got_q.size() == 0) else begin
			$display("case %0d produced more than one result", k);
			time_errs++;
		end
	endtask

	initial begin
		bit ok;
		int k;
		rst          = 1'b1;
		byte_i       = 8'h00;
		byte_valid_i = 1'b0;
		load_table();
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		assert (!result_valid_o && result_o == '0 && expected_seq_o == 1) else begin
			$display("ERR after reset result_valid_o %h result_o %h expected_seq_o %h",
				result_valid_o, result_o, expected_seq_o);
			val_errs++;
		end
		ok = 1'b1;
		for (k = 0; k < msg_tab.size() && ok; k++) begin
			build_msg(k);
			drive_msg();
			wait_result(ok);
			assert (ok) else begin
				$display("timed out waiting for the result of case %0d", k);
				timeouts++;
			end
			if (ok)
				check_case(k);
		end
		$display("checks %0d, value errors %0d, timing errors %0d, timeouts %0d",
			checks, val_errs, time_errs, timeouts);
		if (val_errs + time_errs + timeouts == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: fix_rx.f
+incdir+.
fix_tags_pkg.sv
fix_session_pkg.sv
fix_field_parser.sv
fix_checksum.sv
fix_rx_msg_processor.sv
fix_seq_tracker.sv
fix_rx_top.sv
fix_rx_asserts.sv
fix_rx_tb.sv

// File: Makefile
TOP = fix_rx_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f fix_rx.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f fix_rx.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
